// File: Bender.yml
package:
  name: mips_pipeline

sources:
  - common/cpu_pkg.sv
  - core/fetch_unit.sv
  - core/decode_unit.sv
  - core/hazard_unit.sv
  - core/execute_unit.sv
  - core/memory_unit.sv
  - rtl/cpu_top.sv
  - target: test
    files:
      - bench/cpu_properties.sv
      - bench/cpu_tb.sv

// File: all.f
common/cpu_pkg.sv
core/fetch_unit.sv
core/decode_unit.sv
core/hazard_unit.sv
core/execute_unit.sv
core/memory_unit.sv
rtl/cpu_top.sv
bench/cpu_properties.sv
bench/cpu_tb.sv

// File: bench/cpu_properties.sv
module cpu_properties (
    input logic           clk,
    input logic           arst_n,
    input logic           wb_cyc,
    input logic           wb_stb,
    input logic           wb_we,
    input cpu_pkg::word_t wb_adr,
    input cpu_pkg::word_t wb_dat_w,
    input logic           wb_ack
);
    import cpu_pkg::*;

    int         reset_fails = 0;
    int         fwd_fails = 0;
    int         load_use_fails = 0;
    int         branch_fails = 0;
    int         wait_fails = 0;
    logic       write_ack;
    logic       final_write;
    logic [5:0] fwd_seen;
    logic       load_use_seen;
    logic       not_taken_seen;

    // words the program stores, rebuilt from its constants
    function automatic word_t expected_word(word_t addr);
        word_t r1, r2, r3, r4, r5, r6, r7, r8, val;
        r1 = 32'd13;
        r2 = r1 - 32'd3;
        r3 = r1 + r2;
        r4 = r3 - r1;
        r5 = r4 & r3;
        r6 = r5 | r1;
        r7 = r5 - r6;
        r8 = ($signed(r7) < $signed(r5)) ? 32'd1 : 32'd0;
        case (addr)
            32'h00:  val = r3;
            32'h04:  val = r4;
            32'h08:  val = r5;
            32'h0c:  val = r6;
            32'h10:  val = r7;
            32'h14:  val = r8;
            // loaded from 0x0c, plus five
            32'h20:  val = r6 + 32'd5;
            default: val = 'x;
        endcase
        return val;
    endfunction

    assign write_ack   = wb_cyc && wb_stb && wb_we && wb_ack;
    assign final_write = write_ack && wb_adr == 32'hfc && wb_dat_w == 32'd1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fwd_seen       <= '0;
            load_use_seen  <= 1'b0;
            not_taken_seen <= 1'b0;
        end else if (write_ack) begin
            if (wb_adr <= 32'h14) begin
                fwd_seen[wb_adr[4:2]] <= 1'b1;
            end
            if (wb_adr == 32'h20) begin
                load_use_seen <= 1'b1;
            end
            if (wb_adr == 32'h34) begin
                not_taken_seen <= 1'b1;
            end
        end
    end

    reset_quiet: assert property (@(posedge clk) (!arst_n || $rose(arst_n)) |->
                                  !wb_cyc && !wb_stb && !wb_we)
        else begin
            $error("bus request active during reset or in the first cycle after it");
            reset_fails++;
        end

    fwd_value: assert property (@(posedge clk) disable iff (!arst_n)
                                write_ack && wb_adr <= 32'h14 |->
                                wb_dat_w == expected_word(wb_adr))
        else begin
            $error("FAILED forwarding: addr %h expected %h actual %h", $sampled(wb_adr),
                   expected_word($sampled(wb_adr)), $sampled(wb_dat_w));
            fwd_fails++;
        end

    fwd_all_written: assert property (@(posedge clk) disable iff (!arst_n)
                                      final_write |-> &fwd_seen)
        else begin
            $error("final store came before all forwarding results were stored");
            fwd_fails++;
        end

    load_use_value: assert property (@(posedge clk) disable iff (!arst_n)
                                     write_ack && wb_adr == 32'h20 |->
                                     wb_dat_w == expected_word(32'h20))
        else begin
            $error("FAILED load_use: expected %h actual %h", expected_word(32'h20),
                   $sampled(wb_dat_w));
            load_use_fails++;
        end

    load_use_written: assert property (@(posedge clk) disable iff (!arst_n)
                                       final_write |-> load_use_seen)
        else begin
            $error("final store came before the load-use result was stored");
            load_use_fails++;
        end

    skipped_store: assert property (@(posedge clk) disable iff (!arst_n)
                                    !(write_ack && wb_adr == 32'h30))
        else begin
            $error("an instruction behind a taken branch or jump wrote 0x30");
            branch_fails++;
        end

    not_taken_value: assert property (@(posedge clk) disable iff (!arst_n)
                                      write_ack && wb_adr == 32'h34 |-> wb_dat_w == 32'd7)
        else begin
            $error("FAILED branches: expected %h actual %h", 32'd7, $sampled(wb_dat_w));
            branch_fails++;
        end

    not_taken_written: assert property (@(posedge clk) disable iff (!arst_n)
                                        final_write |-> not_taken_seen)
        else begin
            $error("store after the not-taken beq never reached 0x34");
            branch_fails++;
        end

    wait_hold: assert property (@(posedge clk) disable iff (!arst_n)
                                wb_stb && !wb_ack |=>
                                $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w) && wb_stb)
        else begin
            $error("request changed or dropped while waiting for ack");
            wait_fails++;
        end

    stb_in_cycle: assert property (@(posedge clk) disable iff (!arst_n) wb_stb |-> wb_cyc)
        else begin
            $error("wb_stb high without wb_cyc");
            wait_fails++;
        end

endmodule

bind cpu_top cpu_properties props (.*);

// File: bench/cpu_tb.sv
module cpu_tb;
    import cpu_pkg::*;

    logic        clk;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    word_t       wb_adr;
    word_t       wb_dat_w;
    word_t       wb_dat_r;
    logic        wb_ack;

    word_t       slave_mem [64];
    logic [31:0] rng_state = 32'hf7fe_c110;
    int          waits_left;
    logic        busy;
    logic        final_seen;
    int          cycles;
    int          passed;
    int          failed;
    // program needs under 400 cycles with every access at 3 waits
    int          cycle_limit = 5 * 400;

    cpu_top dut (.*);

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic serve_request();
        if (wb_we) begin
            slave_mem[wb_adr[7:2]] = wb_dat_w;
            if (wb_adr == 32'h0000_00fc && wb_dat_w == 32'd1) begin
                final_seen = 1'b1;
            end
        end else begin
            wb_dat_r = slave_mem[wb_adr[7:2]];
        end
        wb_ack = 1'b1;
    endtask

    task automatic report_test(input string name, input int fails);
        if (fails == 0) begin
            passed++;
            $display("PASSED %s", name);
        end else begin
            failed++;
            $display("FAILED %s with %0d assertion failures", name, fails);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // wishbone slave, 0 to 3 wait states per transfer
    initial begin
        busy       = 1'b0;
        final_seen = 1'b0;
        waits_left = 0;
        for (int i = 0; i < 64; i++) begin
            slave_mem[i] = 32'h5a00_0000 | (i << 2);
        end
        forever begin
            @(posedge clk);
            #2;
            // an ack seen at this edge ended the transfer
            if (wb_ack) begin
                wb_ack = 1'b0;
                busy   = 1'b0;
            end
            if (wb_cyc && wb_stb) begin
                if (!busy) begin
                    busy       = 1'b1;
                    rng_state  = xorshift32(rng_state);
                    waits_left = rng_state[1:0];
                end
                if (waits_left == 0) begin
                    serve_request();
                end else begin
                    waits_left--;
                end
            end
        end
    end

    initial begin
        arst_n   = 1'b1;
        wb_ack   = 1'b0;
        wb_dat_r = '0;
        cycles   = 0;
        passed   = 0;
        failed   = 0;
        #1 arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #2 arst_n = 1'b1;
        while (!final_seen && cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        // let the final ack edge reach the assertions
        repeat (2) @(posedge clk);
        #1;
        report_test("reset", dut.props.reset_fails);
        report_test("forwarding", dut.props.fwd_fails);
        report_test("load_use", dut.props.load_use_fails);
        report_test("branches", dut.props.branch_fails);
        report_test("wait_states", dut.props.wait_fails);
        if (final_seen) begin
            passed++;
            $display("PASSED completion after %0d cycles", cycles);
        end else begin
            failed++;
            $display("FAILED completion, program never reached its final store in %0d cycles",
                     cycle_limit);
        end
        $display("%0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: common/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int IMEM_DEPTH = 64;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [5:0]      opcode_t;
    typedef logic [5:0]      funct_t;

    // opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_J     = 6'h02;

    // r-type function codes
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        alu_op_t  alu_op;
        word_t    operand_1;
        word_t    operand_2;
        word_t    store_data;
        reg_idx_t reg_1_idx;
        reg_idx_t reg_2_idx;
        reg_idx_t reg_dest_idx;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t reg_dest_idx;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        logic     mem_read;
        word_t    alu_result;
        word_t    read_data;
        reg_idx_t reg_dest_idx;
    } mem_wb_t;

    // register file write port, driven from writeback
    typedef struct packed {
        logic     we;
        reg_idx_t idx;
        word_t    data;
    } wb_write_t;

endpackage

// File: core/decode_unit.sv
module decode_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::word_t     if_pc,
    input  cpu_pkg::word_t     if_instr,
    input  logic               stall_id,
    input  logic               freeze,
    input  cpu_pkg::wb_write_t wb,
    output cpu_pkg::id_ex_t    id_ex,
    output logic               redirect,
    output cpu_pkg::word_t     redirect_pc,
    output cpu_pkg::reg_idx_t  id_reg_1_idx,
    output cpu_pkg::reg_idx_t  id_reg_2_idx,
    output logic               id_is_branch
);
    import cpu_pkg::*;

    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    word_t    imm_ext;
    word_t    pc_plus4;
    word_t    rs_data;
    word_t    rt_data;
    word_t    regs [32];
    logic     legal;
    logic     is_imm;
    logic     is_beq;
    logic     is_j;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    alu_op_t  alu_op;
    reg_idx_t dest_idx;

    assign opcode   = if_instr[31:26];
    assign rs       = if_instr[25:21];
    assign rt       = if_instr[20:16];
    assign rd       = if_instr[15:11];
    assign funct    = if_instr[5:0];
    assign imm_ext  = {{16{if_instr[15]}}, if_instr[15:0]};
    assign pc_plus4 = if_pc + 32'd4;

    always_comb begin
        legal     = 1'b1;
        is_imm    = 1'b0;
        is_beq    = 1'b0;
        is_j      = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        alu_op    = ALU_ADD;
        dest_idx  = rd;
        case (opcode)
            OP_RTYPE: begin
                reg_write = 1'b1;
                case (funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: begin
                        legal     = 1'b0;
                        reg_write = 1'b0;
                    end
                endcase
            end
            OP_ADDI: begin
                reg_write = 1'b1;
                is_imm    = 1'b1;
                dest_idx  = rt;
            end
            OP_LW: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                is_imm    = 1'b1;
                dest_idx  = rt;
            end
            OP_SW: begin
                mem_write = 1'b1;
                is_imm    = 1'b1;
            end
            OP_BEQ:  is_beq = 1'b1;
            OP_J:    is_j = 1'b1;
            default: legal = 1'b0;
        endcase
    end

    // only registers actually read count as sources
    assign id_reg_1_idx = (legal && !is_j) ? rs : '0;
    assign id_reg_2_idx = (legal && (!is_imm || mem_write) && !is_j) ? rt : '0;
    assign id_is_branch = is_beq;

    // register file, write-first, r0 hardwired to zero
    always_ff @(posedge clk) begin
        if (wb.we && wb.idx != '0) begin
            regs[wb.idx] <= wb.data;
        end
    end

    assign rs_data = (rs == '0) ? '0 : (wb.we && wb.idx == rs) ? wb.data : regs[rs];
    assign rt_data = (rt == '0) ? '0 : (wb.we && wb.idx == rt) ? wb.data : regs[rt];

    // branch resolution in ID
    assign redirect    = !stall_id && (is_j || (is_beq && rs_data == rt_data));
    assign redirect_pc = is_j ? {pc_plus4[31:28], if_instr[25:0], 2'b00}
                              : pc_plus4 + {imm_ext[29:0], 2'b00};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (!freeze) begin
            if (stall_id) begin
                // bubble into EX
                id_ex.valid     <= 1'b0;
                id_ex.reg_write <= 1'b0;
                id_ex.mem_read  <= 1'b0;
                id_ex.mem_write <= 1'b0;
            end else begin
                id_ex.valid        <= legal;
                id_ex.reg_write    <= reg_write;
                id_ex.mem_read     <= mem_read;
                id_ex.mem_write    <= mem_write;
                id_ex.alu_op       <= alu_op;
                id_ex.operand_1    <= rs_data;
                id_ex.operand_2    <= is_imm ? imm_ext : rt_data;
                id_ex.store_data   <= rt_data;
                id_ex.reg_1_idx    <= id_reg_1_idx;
                id_ex.reg_2_idx    <= id_reg_2_idx;
                id_ex.reg_dest_idx <= dest_idx;
            end
        end
    end

endmodule

// File: core/execute_unit.sv
module execute_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               freeze,
    input  cpu_pkg::id_ex_t    id_ex,
    input  cpu_pkg::fwd_sel_t  sel_1,
    input  cpu_pkg::fwd_sel_t  sel_2,
    input  cpu_pkg::fwd_sel_t  sel_store,
    input  cpu_pkg::wb_write_t wb,
    output cpu_pkg::ex_mem_t   ex_mem
);
    import cpu_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t store_val;
    word_t alu_result;
    logic  less;

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        word_t val;
        case (sel)
            FWD_MEM: val = mem_val;
            FWD_WB:  val = wb_val;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    assign op_a      = fwd_mux(sel_1, id_ex.operand_1, ex_mem.alu_result, wb.data);
    assign op_b      = fwd_mux(sel_2, id_ex.operand_2, ex_mem.alu_result, wb.data);
    assign store_val = fwd_mux(sel_store, id_ex.store_data, ex_mem.alu_result, wb.data);

    // signed compare for slt
    assign less = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, less};
            default: alu_result = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else if (!freeze) begin
            ex_mem.valid        <= id_ex.valid;
            ex_mem.reg_write    <= id_ex.reg_write;
            ex_mem.mem_read     <= id_ex.mem_read;
            ex_mem.mem_write    <= id_ex.mem_write;
            ex_mem.alu_result   <= alu_result;
            ex_mem.store_data   <= store_val;
            ex_mem.reg_dest_idx <= id_ex.reg_dest_idx;
        end
    end

endmodule

// File: core/fetch_unit.sv
module fetch_unit (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           freeze,
    input  logic           stall_id,
    input  logic           flush_id,
    input  logic           redirect,
    input  cpu_pkg::word_t redirect_pc,
    output cpu_pkg::word_t if_pc,
    output cpu_pkg::word_t if_instr
);
    import cpu_pkg::*;

    word_t pc;
    word_t rom [IMEM_DEPTH];
    word_t fetched;
    word_t instr_q;
    logic  valid_q;
    logic  advance;

    initial begin
        $readmemh("program.hex", rom);
    end

    // word addressed rom, wraps past the end
    assign fetched = rom[pc[$clog2(IMEM_DEPTH)+1:2]];
    assign advance = !freeze && !stall_id;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= '0;
            valid_q <= 1'b0;
        end else if (advance) begin
            pc      <= redirect ? redirect_pc : pc + 32'd4;
            // wrong-path fetch dropped on redirect
            valid_q <= !flush_id;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            instr_q <= fetched;
            if_pc   <= pc;
        end
    end

    // empty slot reads as all zeros, which decode treats as illegal
    assign if_instr = valid_q ? instr_q : '0;

endmodule

// File: core/hazard_unit.sv
module hazard_unit (
    input  cpu_pkg::reg_idx_t  id_reg_1_idx,
    input  cpu_pkg::reg_idx_t  id_reg_2_idx,
    input  logic               id_is_branch,
    input  cpu_pkg::id_ex_t    id_ex,
    input  cpu_pkg::ex_mem_t   ex_mem,
    input  cpu_pkg::wb_write_t wb,
    input  logic               redirect,
    input  logic               bus_wait,
    output logic               stall_id,
    output logic               flush_id,
    output logic               freeze,
    output cpu_pkg::fwd_sel_t  sel_1,
    output cpu_pkg::fwd_sel_t  sel_2,
    output cpu_pkg::fwd_sel_t  sel_store
);
    import cpu_pkg::*;

    logic ex_hits_id;
    logic mem_hits_id;
    logic load_use;
    logic branch_dep;

    function automatic logic hits(reg_idx_t dest, reg_idx_t src);
        return dest != '0 && dest == src;
    endfunction

    // MEM result is newer than WB, so it wins
    function automatic fwd_sel_t pick_source(reg_idx_t idx, ex_mem_t mem_st, wb_write_t wb_st);
        fwd_sel_t sel;
        if (mem_st.valid && mem_st.reg_write && hits(mem_st.reg_dest_idx, idx)) begin
            sel = FWD_MEM;
        end else if (wb_st.we && hits(wb_st.idx, idx)) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    assign ex_hits_id = id_ex.valid && id_ex.reg_write &&
                        (hits(id_ex.reg_dest_idx, id_reg_1_idx) ||
                         hits(id_ex.reg_dest_idx, id_reg_2_idx));
    assign mem_hits_id = ex_mem.valid && ex_mem.reg_write &&
                         (hits(ex_mem.reg_dest_idx, id_reg_1_idx) ||
                          hits(ex_mem.reg_dest_idx, id_reg_2_idx));

    assign load_use   = ex_hits_id && id_ex.mem_read;
    // beq compares in ID, so it waits for both EX and MEM writers
    assign branch_dep = id_is_branch && (ex_hits_id || mem_hits_id);

    assign stall_id = load_use || branch_dep;
    assign flush_id = redirect;
    assign freeze   = bus_wait;

    assign sel_1     = pick_source(id_ex.reg_1_idx, ex_mem, wb);
    // sw carries its immediate in operand 2
    assign sel_2     = id_ex.mem_write ? FWD_REG : pick_source(id_ex.reg_2_idx, ex_mem, wb);
    assign sel_store = pick_source(id_ex.reg_2_idx, ex_mem, wb);

endmodule

// File: core/memory_unit.sv
module memory_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::ex_mem_t   ex_mem,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output cpu_pkg::word_t     wb_adr,
    output cpu_pkg::word_t     wb_dat_w,
    input  cpu_pkg::word_t     wb_dat_r,
    input  logic               wb_ack,
    output logic               bus_wait,
    output cpu_pkg::wb_write_t wb
);
    import cpu_pkg::*;

    mem_wb_t mem_wb;
    logic    access;

    // one wishbone transfer per load or store sitting in MEM
    assign access = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);

    // request held stable by the frozen EX/MEM register until ack
    assign wb_cyc   = access;
    assign wb_stb   = access;
    assign wb_we    = access && ex_mem.mem_write;
    assign wb_adr   = ex_mem.alu_result;
    assign wb_dat_w = ex_mem.store_data;

    assign bus_wait = access && !wb_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else if (!bus_wait) begin
            mem_wb.valid        <= ex_mem.valid;
            mem_wb.reg_write    <= ex_mem.reg_write;
            mem_wb.mem_read     <= ex_mem.mem_read;
            mem_wb.alu_result   <= ex_mem.alu_result;
            mem_wb.read_data    <= wb_ack ? wb_dat_r : '0;
            mem_wb.reg_dest_idx <= ex_mem.reg_dest_idx;
        end
    end

    // writeback select
    assign wb.we   = mem_wb.valid && mem_wb.reg_write;
    assign wb.idx  = mem_wb.reg_dest_idx;
    assign wb.data = mem_wb.mem_read ? mem_wb.read_data : mem_wb.alu_result;

endmodule

// File: program.hex
// one instruction word per line, loaded into ROM from word 0
// the assembly of each word follows it on the same line
2001000d // addi r1, r0, 13
2022fffd // addi r2, r1, -3
00221820 // add  r3, r1, r2
00612022 // sub  r4, r3, r1
00832824 // and  r5, r4, r3
00a13025 // or   r6, r5, r1
00a63822 // sub  r7, r5, r6
00e5402a // slt  r8, r7, r5
ac080014 // sw   r8, 0x14(r0)
ac06000c // sw   r6, 0x0c(r0)
ac050008 // sw   r5, 0x08(r0)
ac040004 // sw   r4, 0x04(r0)
ac030000 // sw   r3, 0x00(r0)
ac070010 // sw   r7, 0x10(r0)
8c09000c // lw   r9, 0x0c(r0)
212a0005 // addi r10, r9, 5
ac0a0020 // sw   r10, 0x20(r0)
200b0bad // addi r11, r0, 0xbad
116b0001 // beq  r11, r11, +1
ac0b0030 // sw   r11, 0x30(r0)
200c0007 // addi r12, r0, 7
10220001 // beq  r1, r2, +1
ac0c0034 // sw   r12, 0x34(r0)
08000019 // j    25
ac0b0030 // sw   r11, 0x30(r0)
200d0001 // addi r13, r0, 1
ac0d00fc // sw   r13, 0xfc(r0)
0800001b // j    27

// File: rtl/cpu_top.sv
module cpu_top (
    input  logic           clk,
    input  logic           arst_n,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we,
    output cpu_pkg::word_t wb_adr,
    output cpu_pkg::word_t wb_dat_w,
    input  cpu_pkg::word_t wb_dat_r,
    input  logic           wb_ack
);
    import cpu_pkg::*;

    // stage results
    word_t     if_pc;
    word_t     if_instr;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    wb_write_t wb;

    // control between stages
    logic      redirect;
    word_t     redirect_pc;
    reg_idx_t  id_reg_1_idx;
    reg_idx_t  id_reg_2_idx;
    logic      id_is_branch;
    logic      stall_id;
    logic      flush_id;
    logic      freeze;
    logic      bus_wait;
    fwd_sel_t  sel_1;
    fwd_sel_t  sel_2;
    fwd_sel_t  sel_store;

    fetch_unit fetch_unit (.*);

    decode_unit decode_unit (.*);

    hazard_unit hazard_unit (.*);

    execute_unit execute_unit (.*);

    memory_unit memory_unit (.*);

endmodule
